// ==== design/cpu_pkg.sv ====
package cpu_pkg;

  localparam int xlen = 32;
  localparam int nregs = 16;
  localparam logic [xlen-1:0] reset_pc = '0;

  typedef enum logic [3:0] {
    op_alu_r = 4'h0,
    op_alu_i = 4'h1,
    op_ldw   = 4'h2,
    op_ldb   = 4'h3,
    op_stw   = 4'h4,
    op_stb   = 4'h5,
    op_beq   = 4'h6,
    op_bne   = 4'h7,
    op_halt  = 4'h8   // 9 to f are illegal
  } op_e;

  typedef enum logic [3:0] {
    alu_add = 4'h0,
    alu_sub = 4'h1,
    alu_and = 4'h2,
    alu_or  = 4'h3,
    alu_xor = 4'h4,
    alu_shl = 4'h5,
    alu_shr = 4'h6
  } alu_func_e;

  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_execute,
    st_memory,
    st_writeback,
    st_halted
  } state_e;

  typedef enum logic [1:0] {pc_hold, pc_plus4, pc_branch} pcsel_e;
  typedef enum logic {opsel_reg, opsel_imm} opsel_e;
  typedef enum logic {regsel_alu, regsel_mdr} regsel_e;
  typedef enum logic {marsel_pc, marsel_alu} marsel_e;

  // rd is ra in both formats
  typedef struct packed {
    op_e         op;
    alu_func_e   func;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [3:0]  rc;
    logic [11:0] unused;
  } instr_r_t;

  typedef struct packed {
    op_e                op;
    alu_func_e          func;
    logic [3:0]         ra;
    logic [3:0]         rb;
    logic signed [15:0] imm;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

// ==== design/cpu_regfile.sv ====
`timescale 1ns/1ps

module cpu_regfile (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic [$clog2(cpu_pkg::nregs)-1:0] read_addr1,
  input  logic [$clog2(cpu_pkg::nregs)-1:0] read_addr2,
  input  logic [$clog2(cpu_pkg::nregs)-1:0] write_addr,
  input  logic [cpu_pkg::xlen-1:0]          write_data,
  input  logic                              write_en,
  output logic [cpu_pkg::xlen-1:0]          data1,
  output logic [cpu_pkg::xlen-1:0]          data2
);
  import cpu_pkg::*;

  logic [xlen-1:0] regs [nregs];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && (write_addr != '0)) begin
      regs[write_addr] <= write_data;   // r0 stays zero
    end
  end

  // combinational read
  assign data1 = (read_addr1 == '0) ? '0 : regs[read_addr1];
  assign data2 = (read_addr2 == '0) ? '0 : regs[read_addr2];

endmodule

// ==== design/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu (
  input  logic [cpu_pkg::xlen-1:0] in1,
  input  logic [cpu_pkg::xlen-1:0] in2,
  input  cpu_pkg::alu_func_e       func,
  output logic [cpu_pkg::xlen-1:0] result,
  output logic                     carry,
  output logic                     negative,
  output logic                     overflow,
  output logic                     zero
);
  import cpu_pkg::*;

  logic [xlen:0] wide;   // extra bit for carry out

  always_comb begin
    wide = '0;
    result = '0;
    carry = 1'b0;
    overflow = 1'b0;
    case (func)
      alu_add: begin
        wide = {1'b0, in1} + {1'b0, in2};
        result = wide[xlen-1:0];
        carry = wide[xlen];
        overflow = (in1[xlen-1] == in2[xlen-1]) && (result[xlen-1] != in1[xlen-1]);
      end
      alu_sub: begin
        wide = {1'b0, in1} - {1'b0, in2};
        result = wide[xlen-1:0];
        carry = wide[xlen];   // set on borrow
        overflow = (in1[xlen-1] != in2[xlen-1]) && (result[xlen-1] != in1[xlen-1]);
      end
      alu_and: result = in1 & in2;
      alu_or:  result = in1 | in2;
      alu_xor: result = in1 ^ in2;
      alu_shl: result = in1 << in2[4:0];
      alu_shr: result = in1 >> in2[4:0];   // logical
      default: result = '0;
    endcase
  end

  assign negative = result[xlen-1];
  assign zero = (result == '0);

endmodule

// ==== design/cpu_datapath.sv ====
`timescale 1ns/1ps

module cpu_datapath (
  input  logic                     clk,
  input  logic                     reset_n,
  input  cpu_pkg::pcsel_e          pcsel,
  input  cpu_pkg::opsel_e          operand_sel,
  input  cpu_pkg::regsel_e         regsel,
  input  cpu_pkg::marsel_e         marsel,
  input  logic                     ir_write,
  input  logic                     mdr_write,
  input  logic                     ccr_write,
  input  logic [cpu_pkg::xlen-1:0] alu_result,
  input  logic                     alu_carry,
  input  logic                     alu_negative,
  input  logic                     alu_overflow,
  input  logic                     alu_zero,
  input  logic [cpu_pkg::xlen-1:0] reg_data1,
  input  logic [cpu_pkg::xlen-1:0] reg_data2,
  input  logic [cpu_pkg::xlen-1:0] wb_dat_r,
  input  logic                     byte_op,
  input  logic                     addrsel,
  output cpu_pkg::instr_u          ir,
  output logic                     ccr_zero,
  output logic [cpu_pkg::xlen-1:0] alu_in1,
  output logic [cpu_pkg::xlen-1:0] alu_in2,
  output logic [cpu_pkg::xlen-1:0] reg_write_data,
  output logic [cpu_pkg::xlen-1:0] wb_adr,
  output logic [cpu_pkg::xlen-1:0] wb_dat_w,
  output logic [3:0]               wb_sel
);
  import cpu_pkg::*;

  logic [xlen-1:0] pc, pc_next;
  logic [xlen-1:0] mar, mdr, aluval;
  logic [xlen-1:0] imm_ext, load_data;
  logic [3:0]      ccr;   // carry, negative, overflow, zero
  logic [3:0]      lane_sel;
  logic [7:0]      load_byte;

  assign imm_ext = {{(xlen-16){ir.i.imm[15]}}, ir.i.imm};

  always_comb begin
    case (pcsel)
      pc_plus4:  pc_next = pc + xlen'(4);
      pc_branch: pc_next = pc + xlen'(4) + {imm_ext[xlen-3:0], 2'b00};
      default:   pc_next = pc;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pc <= reset_pc;
      ir <= '0;
      ccr <= '0;
      wb_sel <= '0;
    end else begin
      pc <= pc_next;
      if (ir_write) begin
        ir <= wb_dat_r;
      end
      if (ccr_write) begin
        ccr <= {alu_carry, alu_negative, alu_overflow, alu_zero};
      end
      // lane enables line up with the registered strobe
      wb_sel <= byte_op ? lane_sel : 4'b1111;
    end
  end

  // mar follows marsel every cycle, control keeps it steady through a memory op
  always_ff @(posedge clk) begin
    mar <= (marsel == marsel_alu) ? alu_result : pc;
    aluval <= alu_result;
    if (mdr_write) begin
      mdr <= load_data;
    end
  end

  assign ccr_zero = ccr[0];

  // operands
  assign alu_in1 = reg_data1;
  assign alu_in2 = (operand_sel == opsel_imm) ? imm_ext : reg_data2;

  assign reg_write_data = (regsel == regsel_mdr) ? mdr : aluval;

  // byte lane steering
  assign lane_sel = 4'b0001 << mar[1:0];
  assign load_byte = wb_dat_r[{mar[1:0], 3'b000} +: 8];
  assign load_data = byte_op ? {{(xlen-8){1'b0}}, load_byte} : wb_dat_r;   // zero extend
  assign wb_dat_w = byte_op ? {4{reg_data2[7:0]}} : reg_data2;

  assign wb_adr = addrsel ? mar : pc;

endmodule

// ==== design/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control (
  input  logic                              clk,
  input  logic                              reset_n,
  input  cpu_pkg::instr_u                   ir,
  input  logic                              ccr_zero,
  input  logic                              wb_ack,
  output cpu_pkg::pcsel_e                   pcsel,
  output cpu_pkg::opsel_e                   operand_sel,
  output cpu_pkg::regsel_e                  regsel,
  output cpu_pkg::marsel_e                  marsel,
  output logic                              ir_write,
  output logic                              mdr_write,
  output logic                              ccr_write,
  output logic [$clog2(cpu_pkg::nregs)-1:0] reg_read_addr1,
  output logic [$clog2(cpu_pkg::nregs)-1:0] reg_read_addr2,
  output logic [$clog2(cpu_pkg::nregs)-1:0] reg_write_addr,
  output logic                              reg_write,
  output cpu_pkg::alu_func_e                alu_func,
  output logic                              byte_op,
  output logic                              addrsel,
  output logic                              wb_cyc,
  output logic                              wb_stb,
  output logic                              wb_we,
  output logic                              halt
);
  import cpu_pkg::*;

  state_e state, state_next;
  op_e    op;
  logic   cyc, cyc_next;
  logic   bus_done;
  logic   is_alu, is_load, is_store, is_byte, is_branch, taken;

  assign op = ir.r.op;
  assign is_alu = (op == op_alu_r) || (op == op_alu_i);
  assign is_load = (op == op_ldw) || (op == op_ldb);
  assign is_store = (op == op_stw) || (op == op_stb);
  assign is_byte = (op == op_ldb) || (op == op_stb);
  assign is_branch = (op == op_beq) || (op == op_bne);
  assign taken = (op == op_beq) ? ccr_zero : !ccr_zero;

  assign bus_done = cyc && wb_ack;

  always_comb begin
    state_next = state;
    case (state)
      st_fetch: begin
        if (bus_done) begin
          state_next = st_decode;
        end
      end
      st_decode: state_next = st_execute;
      st_execute: begin
        if (is_alu) begin
          state_next = st_writeback;
        end else if (is_load || is_store) begin
          state_next = st_memory;
        end else if (is_branch) begin
          state_next = st_fetch;
        end else begin
          state_next = st_halted;   // halt or illegal opcode
        end
      end
      st_memory: begin
        if (bus_done) begin
          state_next = is_load ? st_writeback : st_fetch;
        end
      end
      st_writeback: state_next = st_fetch;
      default: state_next = st_halted;
    endcase
  end

  // strobe rises on entry to a bus phase but never right after an ack
  assign cyc_next = ((state_next == st_fetch) || (state_next == st_memory)) && !bus_done;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= st_fetch;
      cyc <= 1'b0;
    end else begin
      state <= state_next;
      cyc <= cyc_next;
    end
  end

  assign wb_cyc = cyc;
  assign wb_stb = cyc;
  assign wb_we = cyc && (state == st_memory) && is_store;
  assign addrsel = (state == st_memory);
  assign byte_op = is_byte && ((state == st_execute) || (state == st_memory));

  assign ir_write = (state == st_fetch) && bus_done;
  assign mdr_write = (state == st_memory) && bus_done && is_load;
  assign ccr_write = (state == st_execute) && is_alu;
  assign reg_write = (state == st_writeback);

  always_comb begin
    pcsel = pc_hold;
    if (state == st_execute) begin
      if (is_branch) begin
        pcsel = taken ? pc_branch : pc_plus4;
      end else if (is_alu || is_load || is_store) begin
        pcsel = pc_plus4;
      end
    end
  end

  assign operand_sel = (op == op_alu_r) ? opsel_reg : opsel_imm;
  assign regsel = is_load ? regsel_mdr : regsel_alu;
  assign marsel = (is_load || is_store) ? marsel_alu : marsel_pc;
  assign alu_func = is_alu ? ir.r.func : alu_add;   // address add otherwise

  assign reg_read_addr1 = ir.r.rb;
  assign reg_read_addr2 = (op == op_alu_r) ? ir.r.rc : ir.r.ra;   // ra is store data
  assign reg_write_addr = ir.r.ra;

  assign halt = (state == st_halted);

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
  input  logic                     clk,
  input  logic                     reset_n,
  output logic                     wb_cyc,
  output logic                     wb_stb,
  output logic                     wb_we,
  output logic [cpu_pkg::xlen-1:0] wb_adr,
  output logic [3:0]               wb_sel,
  output logic [cpu_pkg::xlen-1:0] wb_dat_w,
  input  logic [cpu_pkg::xlen-1:0] wb_dat_r,
  input  logic                     wb_ack,
  output logic                     halt
);
  import cpu_pkg::*;

  pcsel_e    pcsel;
  opsel_e    operand_sel;
  regsel_e   regsel;
  marsel_e   marsel;
  alu_func_e alu_func;
  instr_u    ir;

  logic ir_write, mdr_write, ccr_write, reg_write;
  logic byte_op, addrsel, ccr_zero;
  logic alu_carry, alu_negative, alu_overflow, alu_zero;
  logic [$clog2(nregs)-1:0] reg_read_addr1, reg_read_addr2, reg_write_addr;
  logic [xlen-1:0] alu_in1, alu_in2, alu_result;
  logic [xlen-1:0] reg_data1, reg_data2, reg_write_data;

  cpu_control u_control (
    .clk, .reset_n, .ir, .ccr_zero, .wb_ack,
    .pcsel, .operand_sel, .regsel, .marsel,
    .ir_write, .mdr_write, .ccr_write,
    .reg_read_addr1, .reg_read_addr2, .reg_write_addr, .reg_write,
    .alu_func, .byte_op, .addrsel,
    .wb_cyc, .wb_stb, .wb_we, .halt
  );

  cpu_datapath u_datapath (
    .clk, .reset_n, .pcsel, .operand_sel, .regsel, .marsel,
    .ir_write, .mdr_write, .ccr_write,
    .alu_result, .alu_carry, .alu_negative, .alu_overflow, .alu_zero,
    .reg_data1, .reg_data2, .wb_dat_r, .byte_op, .addrsel,
    .ir, .ccr_zero, .alu_in1, .alu_in2, .reg_write_data,
    .wb_adr, .wb_dat_w, .wb_sel
  );

  cpu_alu u_alu (
    .in1(alu_in1), .in2(alu_in2), .func(alu_func), .result(alu_result),
    .carry(alu_carry), .negative(alu_negative), .overflow(alu_overflow), .zero(alu_zero)
  );

  cpu_regfile u_regfile (
    .clk, .reset_n,
    .read_addr1(reg_read_addr1), .read_addr2(reg_read_addr2), .write_addr(reg_write_addr),
    .write_data(reg_write_data), .write_en(reg_write),
    .data1(reg_data1), .data2(reg_data2)
  );

endmodule

// ==== tests/cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker (
  input logic                     clk,
  input logic                     reset_n,
  input logic                     wb_cyc,
  input logic                     wb_stb,
  input logic                     wb_we,
  input logic [cpu_pkg::xlen-1:0] wb_adr,
  input logic [3:0]               wb_sel,
  input logic [cpu_pkg::xlen-1:0] wb_dat_w,
  input logic                     wb_ack,
  input logic                     halt
);
  int error_count = 0;   // read by the testbench

  function automatic void record_failure(input string what);
    error_count++;
    $error("%s", what);
  endfunction

  // sampled on the first edge after release, so these are the reset values
  idle_after_reset: assert property (@(posedge clk) $rose(reset_n) |->
      !wb_cyc && !wb_stb && !wb_we && !halt && (wb_sel == '0))
    else record_failure("bus or halt active when reset was released");

  stb_inside_cyc: assert property (@(posedge clk) disable iff (!reset_n)
      (wb_stb || wb_we) |-> wb_cyc)
    else record_failure("stb or we high without cyc");

  hold_until_ack: assert property (@(posedge clk) disable iff (!reset_n)
      wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_sel)
        && $stable(wb_we) && $stable(wb_dat_w))
    else record_failure("bus request changed before ack");

  gap_after_ack: assert property (@(posedge clk) disable iff (!reset_n)
      wb_stb && wb_ack |=> !wb_stb)
    else record_failure("new strobe in the cycle right after ack");

  quiet_after_halt: assert property (@(posedge clk) disable iff (!reset_n)
      halt |-> !wb_cyc ##1 halt)
    else record_failure("bus cycle or halt drop after halt");

endmodule

bind cpu_top cpu_checker protocol_check (
  .clk(clk), .reset_n(reset_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
  .wb_adr(wb_adr), .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .halt(halt)
);

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
  import cpu_pkg::*;

  localparam int cycle_limit = 2000;   // about 60 instructions of at most 12 cycles
  localparam logic [31:0] res_base = 32'h200;

  logic clk = 1'b0;
  logic reset_n, wb_cyc, wb_stb, wb_we, wb_ack, halt;
  logic [31:0] wb_adr, wb_dat_w, wb_dat_r;
  logic [3:0] wb_sel;
  logic [31:0] mem [256];
  logic [31:0] exp_adr [$];
  logic [31:0] exp_dat [$];
  logic [3:0] exp_sel [$];
  logic [1:0] wait_table [512];
  int prog_len, xfer_count, wait_left, cycle_count;
  bit busy;

  cpu_top DUT (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] encode(op_e op, int func, int ra, int rb, int low);
    return {op, 4'(func), 4'(ra), 4'(rb), 16'(low)};
  endfunction

  // reference arithmetic with shifts on the low 5 bits of y
  function automatic logic [31:0] alu_model(int func, logic [31:0] x, logic [31:0] y);
    case (func)
      0: return x + y;
      1: return x - y;
      2: return x & y;
      3: return x | y;
      4: return x ^ y;
      5: return x << y[4:0];
      default: return x >> y[4:0];
    endcase
  endfunction

  task automatic stop_failed();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic mismatch(input string what);
    $display("Fail at %0d ns: %s", $time, what);
    stop_failed();
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    stop_failed();
  endtask

  task automatic fill_memory();
    foreach (mem[i]) mem[i] = {8'hee, 8'(i), 8'(i ^ 'h5a), 8'(i * 3)};   // op e is illegal
    prog_len = 0;
  endtask

  task automatic put_instr(input logic [31:0] word);
    mem[prog_len] = word;
    prog_len++;
  endtask

  task automatic expect_store(input logic [31:0] adr, input logic [3:0] sel,
                              input logic [31:0] dat);
    exp_adr.push_back(adr);
    exp_sel.push_back(sel);
    exp_dat.push_back(dat);
  endtask

  task automatic store_word(input int rs, input logic [31:0] adr, input logic [31:0] dat);
    put_instr(encode(op_stw, 0, rs, 0, adr));
    expect_store(adr, 4'hf, dat);
  endtask

  task automatic check_store();
    logic [31:0] mask;
    int idx;
    idx = wb_adr[9:2];
    mask = {{8{wb_sel[3]}}, {8{wb_sel[2]}}, {8{wb_sel[1]}}, {8{wb_sel[0]}}};
    assert (exp_adr.size() > 0) else abort_run($sformatf("unexpected store to 0x%08h", wb_adr));
    assert (wb_adr == exp_adr[0] && wb_sel == exp_sel[0])
      else mismatch($sformatf("store to 0x%08h sel %b, expected 0x%08h sel %b",
                              wb_adr, wb_sel, exp_adr[0], exp_sel[0]));
    assert ((wb_dat_w & mask) == exp_dat[0])
      else mismatch($sformatf("store data 0x%08h at 0x%08h, expected 0x%08h",
                              wb_dat_w & mask, wb_adr, exp_dat[0]));
    mem[idx] = (mem[idx] & ~mask) | (wb_dat_w & mask);
    void'(exp_adr.pop_front());
    void'(exp_sel.pop_front());
    void'(exp_dat.pop_front());
  endtask

  // slave answers each strobe after 0 to 3 wait cycles
  always @(negedge clk) begin
    if (!reset_n || wb_ack) begin
      wb_ack = 1'b0;
      busy = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!busy) begin
        busy = 1'b1;
        wait_left = wait_table[xfer_count % 512];
        xfer_count++;
      end
      if (wait_left > 0) begin
        wait_left--;
      end else begin
        wb_ack = 1'b1;
        wb_dat_r = mem[wb_adr[9:2]];
        if (wb_we) begin
          check_store();
        end
      end
    end
  end

  always @(negedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      abort_run("Timeout: the core did not halt within the cycle limit");
    end
    if (DUT.protocol_check.error_count != 0) begin
      abort_run("A bus protocol assertion failed in the checker");
    end
  end

  task automatic run_to_halt();
    while (!halt) @(negedge clk);
    repeat (4) begin
      @(negedge clk);
      assert (halt && !wb_cyc) else abort_run("Bus cycle or halt drop seen after halt");
    end
  endtask

  initial begin
    logic [7:0] lane_byte;
    logic [31:0] lane_word;
    void'($urandom(895));
    foreach (wait_table[i]) wait_table[i] = 2'($urandom_range(3, 0));
    reset_n = 1'b0;
    wb_ack = 1'b0;
    wb_dat_r = '0;
    fill_memory();
    put_instr(encode(op_alu_i, alu_add, 1, 0, 100));
    put_instr(encode(op_alu_i, alu_add, 2, 0, -7));
    for (int f = 0; f < 7; f++) begin
      put_instr(encode(op_alu_r, f, 3, 1, 2 << 12));
      store_word(3, res_base + 8 * f, alu_model(f, 100, -7));
      put_instr(encode(op_alu_i, f, 4, 2, -300));   // negative immediate
      store_word(4, res_base + 8 * f + 4, alu_model(f, -7, -300));
    end
    lane_word = '0;
    for (int lane = 0; lane < 4; lane++) begin
      lane_byte = 8'(8'h3c + lane * 8'h47);
      lane_word[8 * lane +: 8] = lane_byte;
      put_instr(encode(op_alu_i, alu_add, 5, 0, 8'h3c + lane * 8'h47));
      put_instr(encode(op_stb, 0, 5, 0, 'h240 + lane));
      expect_store('h240 + lane, 4'b0001 << lane, 32'(lane_byte) << (8 * lane));
    end
    put_instr(encode(op_ldb, 0, 6, 0, 'h242));
    store_word(6, 'h248, {24'h0, lane_word[23:16]});
    put_instr(encode(op_ldw, 0, 7, 0, 'h240));
    store_word(7, 'h24c, lane_word);
    // taken beq, then not-taken beq and taken bne
    put_instr(encode(op_alu_i, alu_add, 8, 0, 'hb1));
    put_instr(encode(op_alu_r, alu_sub, 9, 1, 1 << 12));   // zero result
    put_instr(encode(op_beq, 0, 0, 0, 1));
    put_instr(encode(op_stw, 0, 1, 0, 'h2f0));   // skipped
    store_word(8, 'h250, 'hb1);
    put_instr(encode(op_alu_i, alu_add, 8, 0, 'hc2));
    put_instr(encode(op_beq, 0, 0, 0, 1));
    store_word(8, 'h254, 'hc2);
    put_instr(encode(op_bne, 0, 0, 0, 1));
    put_instr(encode(op_stw, 0, 1, 0, 'h2f4));   // skipped
    put_instr(encode(op_halt, 0, 0, 0, 0));
    repeat (2) @(negedge clk);
    reset_n = 1'b1;
    run_to_halt();
    assert (exp_adr.size() == 0) else abort_run("Some expected stores never reached the bus");

    // second run ends on an illegal opcode
    reset_n = 1'b0;
    fill_memory();
    put_instr(encode(op_alu_i, alu_add, 1, 0, 5));
    put_instr(32'h9000_0000);
    put_instr(encode(op_stw, 0, 1, 0, 'h200));
    repeat (2) @(negedge clk);
    reset_n = 1'b1;
    run_to_halt();
    if (DUT.protocol_check.error_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      abort_run("A bus protocol assertion failed in the checker");
    end
  end

endmodule

// ==== files.f ====
design/cpu_pkg.sv
design/cpu_regfile.sv
design/cpu_alu.sv
design/cpu_datapath.sv
design/cpu_control.sv
design/cpu_top.sv
tests/cpu_checker.sv
tests/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - files:
      - design/cpu_pkg.sv
      - design/cpu_regfile.sv
      - design/cpu_alu.sv
      - design/cpu_datapath.sv
      - design/cpu_control.sv
      - design/cpu_top.sv
  - target: test
    files:
      - tests/cpu_checker.sv
      - tests/cpu_tb.sv
